/* common/spi_pkg.sv */
package spi_pkg;

  // Address windows
  localparam logic [31:0] FLASH_BASE = 32'h3000_0000;
  localparam logic [31:0] FLASH_LAST = 32'h3fff_ffff;
  localparam logic [31:0] CTRL_BASE  = 32'h1000_1000;
  localparam logic [31:0] CTRL_LAST  = 32'h1000_1fff;

  // Slave select lines
  localparam int unsigned SS_NUM = 8;

  // XIP read setup
  localparam logic [15:0] XIP_DIVIDER    = 16'd1;
  localparam logic [7:0]  FLASH_READ_CMD = 8'h03;

  // CTRL register fields
  localparam int unsigned CTRL_LEN_W  = 7;
  localparam int unsigned CTRL_GO_BIT = 8;
  localparam int unsigned CTRL_IE_BIT = 12;

  // Register offsets inside the controller window
  typedef enum logic [4:0] {
    RX0_TX0 = 5'h00,
    RX1_TX1 = 5'h04,
    CTRL    = 5'h10,
    DIVIDER = 5'h14,
    SS      = 5'h18
  } reg_addr_e;

  // Flash read sequence, one register access per state
  typedef enum logic [2:0] {
    IDLE, LOAD_TX1, LOAD_TX0, SET_DIV, SET_SS, GO, POLL, FINISH
  } xip_state_e;

  // Internal register port request
  typedef struct packed {
    logic        valid;
    logic        we;
    reg_addr_e   addr;
    logic [31:0] wdata;
    logic [3:0]  strb;
  } reg_req_t;

  typedef struct packed {
    logic [31:0] rdata;
  } reg_rsp_t;

  // Register file to shift engine
  typedef struct packed {
    logic                  go;
    logic [CTRL_LEN_W-1:0] len;
    logic [15:0]           divider;
    logic [63:0]           tx;
  } shift_cmd_t;

  typedef struct packed {
    logic        busy;
    logic        done;
    logic [63:0] rx;
  } shift_stat_t;

endpackage

/* logic/apb_xip_mux.sv */
`timescale 1ns/10ps

module apb_xip_mux import spi_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic [31:0] paddr_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [31:0] pwdata_i,
  input  logic [3:0]  pstrb_i,
  output logic        pready_o,
  output logic [31:0] prdata_o,
  output logic        pslverr_o,
  input  reg_req_t    xip_req_i,
  output logic        xip_start_o,
  output logic [23:0] xip_addr_o,
  input  logic        xip_done_i,
  input  logic [31:0] xip_data_i,
  output reg_req_t    reg_req_o,
  input  reg_rsp_t    reg_rsp_i
);

  logic     in_flash;
  logic     in_ctrl;
  logic     access;
  logic     bad_access;
  logic     xip_active_q;
  reg_req_t apb_req;

  // Window decode
  assign in_flash = (paddr_i >= FLASH_BASE) && (paddr_i <= FLASH_LAST);
  assign in_ctrl  = (paddr_i >= CTRL_BASE) && (paddr_i <= CTRL_LAST);
  assign access   = psel_i & penable_i;

  // Flash is read only, everything outside both windows is unmapped
  assign bad_access = (in_flash & pwrite_i) | ~(in_flash | in_ctrl);

  // Kick the sequencer once per flash read
  assign xip_start_o = access & in_flash & ~pwrite_i & ~xip_active_q;
  assign xip_addr_o  = paddr_i[23:0];

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      xip_active_q <= 1'b0;
    end else if (xip_start_o) begin
      xip_active_q <= 1'b1;
    end else if (xip_done_i) begin
      xip_active_q <= 1'b0;
    end
  end

  // Controller access goes straight to the register port
  always_comb begin
    apb_req       = '0;
    apb_req.valid = access & in_ctrl;
    apb_req.we    = pwrite_i;
    apb_req.addr  = reg_addr_e'(paddr_i[4:0]);
    apb_req.wdata = pwdata_i;
    apb_req.strb  = pstrb_i;
  end

  assign reg_req_o = xip_active_q ? xip_req_i : apb_req;

  // Zero wait states except for flash reads
  assign pready_o  = access & (in_ctrl | bad_access | (in_flash & xip_done_i));
  assign pslverr_o = access & bad_access;
  assign prdata_o  = in_flash ? xip_data_i : reg_rsp_i.rdata;

  // Sequencer only talks while a flash read is pending
  a_xip_req_active: assert property (@(posedge clock) disable iff (reset)
    xip_req_i.valid |-> xip_active_q);

endmodule

/* xip/xip_sequencer.sv */
`timescale 1ns/10ps

module xip_sequencer import spi_pkg::*; (
  input  logic        clock,
  input  logic        reset,
  input  logic        xip_start_i,
  input  logic [23:0] xip_addr_i,
  output reg_req_t    xip_req_o,
  input  reg_rsp_t    xip_rsp_i,
  output logic        xip_done_o,
  output logic [31:0] xip_data_o
);

  xip_state_e  state_q;
  logic [23:0] addr_q;

  // Flash address held for the command word
  always_ff @(posedge clock) begin
    if (xip_start_i) begin
      addr_q <= xip_addr_i;
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      state_q <= IDLE;
    end else begin
      case (state_q)
        IDLE:     if (xip_start_i) state_q <= LOAD_TX1;
        LOAD_TX1: state_q <= LOAD_TX0;
        LOAD_TX0: state_q <= SET_DIV;
        SET_DIV:  state_q <= SET_SS;
        SET_SS:   state_q <= GO;
        GO:       state_q <= POLL;
        // Wait for the shifter to drop busy
        POLL:     if (!xip_rsp_i.rdata[CTRL_GO_BIT]) state_q <= FINISH;
        FINISH:   state_q <= IDLE;
        default:  state_q <= IDLE;
      endcase
    end
  end

  // One register access per state
  always_comb begin
    xip_req_o      = '0;
    xip_req_o.strb = 4'hf;
    case (state_q)
      LOAD_TX1: begin
        xip_req_o.valid = 1'b1;
        xip_req_o.we    = 1'b1;
        xip_req_o.addr  = RX1_TX1;
        // Command byte and 24-bit address go out first
        xip_req_o.wdata = {FLASH_READ_CMD, addr_q};
      end
      LOAD_TX0: begin
        xip_req_o.valid = 1'b1;
        xip_req_o.we    = 1'b1;
        xip_req_o.addr  = RX0_TX0;
      end
      SET_DIV: begin
        xip_req_o.valid = 1'b1;
        xip_req_o.we    = 1'b1;
        xip_req_o.addr  = DIVIDER;
        xip_req_o.wdata = {16'h0000, XIP_DIVIDER};
      end
      SET_SS: begin
        xip_req_o.valid = 1'b1;
        xip_req_o.we    = 1'b1;
        xip_req_o.addr  = SS;
        xip_req_o.wdata = 32'd1;
      end
      GO: begin
        // char_len of zero gives 64 bits
        xip_req_o.valid              = 1'b1;
        xip_req_o.we                 = 1'b1;
        xip_req_o.addr               = CTRL;
        xip_req_o.wdata[CTRL_GO_BIT] = 1'b1;
      end
      POLL: begin
        xip_req_o.valid = 1'b1;
        xip_req_o.addr  = CTRL;
      end
      FINISH: begin
        xip_req_o.valid = 1'b1;
        xip_req_o.addr  = RX0_TX0;
      end
      default: ;
    endcase
  end

  // Data word is valid only with the final read
  assign xip_done_o = (state_q == FINISH);
  assign xip_data_o = xip_done_o ? xip_rsp_i.rdata : 32'd0;

  a_start_in_idle: assert property (@(posedge clock) disable iff (reset)
    xip_start_i |-> state_q == IDLE);

endmodule

/* spi/spi_regs.sv */
`timescale 1ns/10ps

module spi_regs import spi_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  reg_req_t          reg_req_i,
  output reg_rsp_t          reg_rsp_o,
  output shift_cmd_t        cmd_o,
  input  shift_stat_t       stat_i,
  output logic [SS_NUM-1:0] ss_sel_o,
  output logic              irq_o
);

  logic [31:0]           tx0_q;
  logic [31:0]           tx1_q;
  logic [CTRL_LEN_W-1:0] char_len_q;
  logic                  ie_q;
  logic                  go_q;
  logic [15:0]           divider_q;
  logic [SS_NUM-1:0]     ss_q;
  logic                  wr_en;
  logic                  ctrl_wr;

  function automatic logic [31:0] apply_strb(input logic [31:0] old_v,
                                             input logic [31:0] new_v,
                                             input logic [3:0]  strb);
    logic [31:0] res;
    res = old_v;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) res[8*i +: 8] = new_v[8*i +: 8];
    end
    return res;
  endfunction

  assign wr_en   = reg_req_i.valid & reg_req_i.we;
  assign ctrl_wr = wr_en & (reg_req_i.addr == CTRL);

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      tx0_q      <= '0;
      tx1_q      <= '0;
      char_len_q <= '0;
      ie_q       <= 1'b0;
      go_q       <= 1'b0;
      divider_q  <= '0;
      ss_q       <= '0;
    end else begin
      go_q <= 1'b0;
      if (wr_en) begin
        case (reg_req_i.addr)
          RX0_TX0: tx0_q <= apply_strb(tx0_q, reg_req_i.wdata, reg_req_i.strb);
          RX1_TX1: tx1_q <= apply_strb(tx1_q, reg_req_i.wdata, reg_req_i.strb);
          CTRL: begin
            if (reg_req_i.strb[0]) char_len_q <= reg_req_i.wdata[CTRL_LEN_W-1:0];
            if (reg_req_i.strb[1]) begin
              ie_q <= reg_req_i.wdata[CTRL_IE_BIT];
              // Ignore go while a transfer is running or just launched
              go_q <= reg_req_i.wdata[CTRL_GO_BIT] & ~stat_i.busy & ~go_q;
            end
          end
          DIVIDER: begin
            if (reg_req_i.strb[0]) divider_q[7:0]  <= reg_req_i.wdata[7:0];
            if (reg_req_i.strb[1]) divider_q[15:8] <= reg_req_i.wdata[15:8];
          end
          SS: if (reg_req_i.strb[0]) ss_q <= reg_req_i.wdata[SS_NUM-1:0];
          default: ;
        endcase
      end
    end
  end

  // Interrupt flag, any CTRL write acknowledges it
  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      irq_o <= 1'b0;
    end else if (ctrl_wr) begin
      irq_o <= 1'b0;
    end else if (stat_i.done && ie_q) begin
      irq_o <= 1'b1;
    end
  end

  // Read mux, combinational
  always_comb begin
    reg_rsp_o = '0;
    case (reg_req_i.addr)
      RX0_TX0: reg_rsp_o.rdata = stat_i.rx[31:0];
      RX1_TX1: reg_rsp_o.rdata = stat_i.rx[63:32];
      CTRL: begin
        reg_rsp_o.rdata[CTRL_LEN_W-1:0] = char_len_q;
        // go strobe counts as busy so a poll right after go sees it
        reg_rsp_o.rdata[CTRL_GO_BIT]    = stat_i.busy | go_q;
        reg_rsp_o.rdata[CTRL_IE_BIT]    = ie_q;
      end
      DIVIDER: reg_rsp_o.rdata[15:0]       = divider_q;
      SS:      reg_rsp_o.rdata[SS_NUM-1:0] = ss_q;
      default: ;
    endcase
  end

  assign cmd_o    = '{go: go_q, len: char_len_q, divider: divider_q, tx: {tx1_q, tx0_q}};
  assign ss_sel_o = ss_q;

  a_no_go_busy: assert property (@(posedge clock) disable iff (reset)
    cmd_o.go |-> !stat_i.busy);

endmodule

/* spi/spi_shifter.sv */
`timescale 1ns/10ps

module spi_shifter import spi_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  shift_cmd_t        cmd_i,
  output shift_stat_t       stat_o,
  input  logic [SS_NUM-1:0] ss_sel_i,
  output logic              sck_o,
  output logic [SS_NUM-1:0] ss_o,
  output logic              mosi_o,
  input  logic              miso_i
);

  logic                  busy_q;
  logic                  done_q;
  logic [63:0]           shreg_q;
  logic [15:0]           div_q;
  logic [15:0]           cnt_q;
  logic [7:0]            edges_q;
  logic                  miso_q;
  logic [CTRL_LEN_W-1:0] eff_len;
  logic [CTRL_LEN_W-1:0] shamt;

  // Zero length means a full 64-bit frame
  assign eff_len = (cmd_i.len == '0) ? CTRL_LEN_W'(64) : cmd_i.len;
  assign shamt   = CTRL_LEN_W'(64) - eff_len;

  // Shift register and latched divider
  always_ff @(posedge clock) begin
    if (cmd_i.go) begin
      // Left-align so rx ends right-aligned
      shreg_q <= cmd_i.tx << shamt;
      div_q   <= cmd_i.divider;
    end else if (busy_q && cnt_q == div_q) begin
      if (!sck_o) miso_q <= miso_i;
      else shreg_q <= {shreg_q[62:0], miso_q};
    end
  end

  always_ff @(posedge clock or posedge reset) begin
    if (reset) begin
      busy_q  <= 1'b0;
      done_q  <= 1'b0;
      sck_o   <= 1'b0;
      cnt_q   <= '0;
      edges_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (cmd_i.go) begin
        busy_q  <= 1'b1;
        cnt_q   <= '0;
        edges_q <= {eff_len, 1'b0};
      end else if (busy_q) begin
        if (cnt_q == div_q) begin
          // Toggle SCK when the half period ends
          cnt_q   <= '0;
          sck_o   <= ~sck_o;
          edges_q <= edges_q - 8'd1;
          if (edges_q == 8'd1) begin
            busy_q <= 1'b0;
            done_q <= 1'b1;
          end
        end else begin
          cnt_q <= cnt_q + 16'd1;
        end
      end
    end
  end

  // Mode 0 with the MSB leading
  assign mosi_o = shreg_q[63];
  assign ss_o   = busy_q ? ~ss_sel_i : '1;
  assign stat_o = '{busy: busy_q, done: done_q, rx: shreg_q};

endmodule

/* logic/spi_apb_top.sv */
`timescale 1ns/10ps

module spi_apb_top import spi_pkg::*; (
  input  logic              clock,
  input  logic              reset,
  input  logic [31:0]       paddr_i,
  input  logic              psel_i,
  input  logic              penable_i,
  input  logic              pwrite_i,
  input  logic [31:0]       pwdata_i,
  input  logic [3:0]        pstrb_i,
  output logic              pready_o,
  output logic [31:0]       prdata_o,
  output logic              pslverr_o,
  output logic              sck_o,
  output logic [SS_NUM-1:0] ss_o,
  output logic              mosi_o,
  input  logic              miso_i,
  output logic              irq_o
);

  reg_req_t          xip_req;
  reg_rsp_t          reg_rsp;
  reg_req_t          reg_req;
  logic              xip_start;
  logic [23:0]       xip_addr;
  logic              xip_done;
  logic [31:0]       xip_data;
  shift_cmd_t        shift_cmd;
  shift_stat_t       shift_stat;
  logic [SS_NUM-1:0] ss_sel;

  apb_xip_mux u_apb_xip_mux (
    .clock, .reset, .paddr_i, .psel_i, .penable_i, .pwrite_i, .pwdata_i, .pstrb_i,
    .pready_o, .prdata_o, .pslverr_o,
    .xip_req_i(xip_req), .xip_start_o(xip_start), .xip_addr_o(xip_addr),
    .xip_done_i(xip_done), .xip_data_i(xip_data),
    .reg_req_o(reg_req), .reg_rsp_i(reg_rsp)
  );

  // Same register response feeds both sides
  xip_sequencer u_xip_sequencer (
    .clock, .reset, .xip_start_i(xip_start), .xip_addr_i(xip_addr),
    .xip_req_o(xip_req), .xip_rsp_i(reg_rsp),
    .xip_done_o(xip_done), .xip_data_o(xip_data)
  );

  spi_regs u_spi_regs (
    .clock, .reset, .reg_req_i(reg_req), .reg_rsp_o(reg_rsp),
    .cmd_o(shift_cmd), .stat_i(shift_stat), .ss_sel_o(ss_sel), .irq_o
  );

  spi_shifter u_spi_shifter (
    .clock, .reset, .cmd_i(shift_cmd), .stat_o(shift_stat), .ss_sel_i(ss_sel),
    .sck_o, .ss_o, .mosi_o, .miso_i
  );

endmodule

/* dv/flash_model.sv */
`timescale 1ns/10ps

module flash_model (
  input  logic sck_i,
  input  logic ss_n_i,
  input  logic mosi_i,
  output logic miso_o
);

  logic [31:0] hdr;
  logic [7:0]  cur_byte;
  int unsigned bit_cnt;
  int unsigned data_bit;

  // Array contents follow the address bytes
  function automatic logic [7:0] byte_at(input logic [23:0] a);
    return a[7:0] ^ a[15:8] ^ 8'h5a;
  endfunction

  initial begin
    miso_o = 1'b0;
    hdr    = '0;
    forever begin
      @(negedge ss_n_i);
      bit_cnt = 0;
      miso_o  = 1'b0;
      while (!ss_n_i) begin
        // Command and address sampled on rising SCK
        @(posedge sck_i or posedge ss_n_i);
        if (!ss_n_i) begin
          if (bit_cnt < 32) begin
            hdr = {hdr[30:0], mosi_i};
          end
          bit_cnt++;
          @(negedge sck_i or posedge ss_n_i);
          // Read data shifted out on falling SCK, MSB first
          if (!ss_n_i && bit_cnt >= 32 && hdr[31:24] == 8'h03) begin
            data_bit = bit_cnt - 32;
            cur_byte = byte_at(hdr[23:0] + 24'(data_bit / 8));
            miso_o   = cur_byte[7 - data_bit % 8];
          end
        end
      end
    end
  end

endmodule

/* dv/tb_spi_apb.sv */
`timescale 1ns/10ps

module tb_spi_apb import spi_pkg::*; ();

  localparam int unsigned NUM_REG_WR   = 24;
  localparam int unsigned NUM_LOOPBACK = 12;
  localparam int unsigned NUM_FLASH    = 20;
  // 40 transfers at the longest length and divider, plus register traffic
  localparam int unsigned MAX_XFER_CLK = 64 * 2 * 4 + 40;
  localparam int unsigned TIMEOUT_CLK  = 40 * MAX_XFER_CLK + 2000;

  logic              clock;
  logic              reset;
  logic [31:0]       paddr;
  logic              psel;
  logic              penable;
  logic              pwrite;
  logic [31:0]       pwdata;
  logic [3:0]        pstrb;
  logic              pready;
  logic [31:0]       prdata;
  logic              pslverr;
  logic              sck;
  logic [SS_NUM-1:0] ss;
  logic              mosi;
  logic              miso;
  logic              flash_miso;
  logic              irq;

  // Reference copies of the writable registers
  logic [31:0]       tx0_m;
  logic [31:0]       tx1_m;
  logic [15:0]       div_m;
  logic [SS_NUM-1:0] ss_m;

  logic [31:0] rng_state;
  int unsigned err_cnt;
  int unsigned check_cnt;
  int unsigned cycle_cnt = 0;

  spi_apb_top dut_i (
    .clock, .reset, .paddr_i(paddr), .psel_i(psel), .penable_i(penable),
    .pwrite_i(pwrite), .pwdata_i(pwdata), .pstrb_i(pstrb),
    .pready_o(pready), .prdata_o(prdata), .pslverr_o(pslverr),
    .sck_o(sck), .ss_o(ss), .mosi_o(mosi), .miso_i(miso), .irq_o(irq)
  );

  flash_model u_flash (.sck_i(sck), .ss_n_i(ss[0]), .mosi_i(mosi), .miso_o(flash_miso));

  // Slave 0 is the flash, slave 1 loops MOSI back
  assign miso = !ss[0] ? flash_miso : (!ss[1] ? mosi : 1'b0);

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  always @(posedge clock) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CLK) begin
      $display("Run stopped after %0d cycles, an access or transfer never ended", cycle_cnt);
      $display("TEST FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_rand();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // Upper LCG bits, the low ones repeat quickly
  function automatic int unsigned rand_below(input int unsigned n);
    return (next_rand() >> 8) % n;
  endfunction

  function automatic logic [31:0] strb_merge(input logic [31:0] old_v,
                                             input logic [31:0] new_v,
                                             input logic [3:0]  strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_v & ~mask) | (new_v & mask);
  endfunction

  function automatic logic [7:0] flash_byte(input logic [23:0] a);
    return a[7:0] ^ a[15:8] ^ 8'h5a;
  endfunction

  task automatic check_data(input string name, input logic [31:0] got,
                            input logic [31:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %s got %h expected %h", name, got, exp);
    end
  endtask

  // Pair is {pready in first access cycle, pslverr}
  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %s pready/pslverr got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_irq(input string name, input logic got, input logic exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %s irq_o got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_ss(input string name, input logic [SS_NUM-1:0] got,
                          input logic [SS_NUM-1:0] exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("[ERROR] %s ss_o got %h expected %h", name, got, exp);
    end
  endtask

  // Drive on rising edge, sample on falling edge
  task automatic apb_access(input logic we, input logic [31:0] addr, input logic [31:0] wdata,
                            input logic [3:0] strb, output logic [31:0] rdata,
                            output logic [1:0] resp);
    logic first;
    @(posedge clock);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= we;
    paddr   <= addr;
    pwdata  <= wdata;
    pstrb   <= strb;
    @(posedge clock);
    penable <= 1'b1;
    @(negedge clock);
    first = pready;
    while (!pready) @(negedge clock);
    rdata = prdata;
    resp  = {first, pslverr};
    @(posedge clock);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic reg_write(input reg_addr_e offs, input logic [31:0] data,
                           input logic [3:0] strb);
    logic [31:0] rdata;
    logic [1:0]  resp;
    apb_access(1'b1, CTRL_BASE + 32'(offs), data, strb, rdata, resp);
    check_resp("register write", resp, 2'b10);
  endtask

  task automatic reg_read(input reg_addr_e offs, output logic [31:0] rdata);
    logic [1:0] resp;
    apb_access(1'b0, CTRL_BASE + 32'(offs), 32'd0, 4'h0, rdata, resp);
    check_resp("register read", resp, 2'b10);
  endtask

  task automatic wait_idle();
    logic [31:0] rdata;
    rdata = 32'd1 << CTRL_GO_BIT;
    while (rdata[CTRL_GO_BIT]) reg_read(CTRL, rdata);
  endtask

  task automatic write_tx_random(input reg_addr_e offs);
    logic [31:0] data;
    logic [3:0]  strb;
    data = next_rand();
    strb = 4'(rand_below(16));
    reg_write(offs, data, strb);
    if (offs == RX0_TX0) tx0_m = strb_merge(tx0_m, data, strb);
    else tx1_m = strb_merge(tx1_m, data, strb);
  endtask

  task automatic random_reg_writes();
    logic [31:0] data;
    logic [31:0] word;
    logic [3:0]  strb;
    logic [31:0] rdata;
    for (int unsigned i = 0; i < NUM_REG_WR; i++) begin
      case (2'(rand_below(4)))
        2'd0: write_tx_random(RX0_TX0);
        2'd1: write_tx_random(RX1_TX1);
        2'd2: begin
          data = next_rand();
          strb = 4'(rand_below(16));
          reg_write(DIVIDER, data, strb);
          word  = strb_merge({16'h0000, div_m}, data, {2'b00, strb[1:0]});
          div_m = word[15:0];
          reg_read(DIVIDER, rdata);
          check_data("divider readback", rdata, {16'h0000, div_m});
        end
        default: begin
          data = next_rand();
          strb = 4'(rand_below(16));
          reg_write(SS, data, strb);
          word = strb_merge(32'(ss_m), data, {3'b000, strb[0]});
          ss_m = word[SS_NUM-1:0];
          reg_read(SS, rdata);
          check_data("ss readback", rdata, 32'(ss_m));
        end
      endcase
    end
  endtask

  task automatic loopback_transfer();
    int unsigned len;
    int unsigned high_clk;
    logic [15:0] div;
    logic [63:0] mask;
    logic [63:0] exp_rx;
    logic [31:0] rdata;
    write_tx_random(RX0_TX0);
    write_tx_random(RX1_TX1);
    len   = rand_below(64) + 1;
    div   = 16'(rand_below(4));
    div_m = div;
    ss_m  = 8'h02;
    reg_write(DIVIDER, {16'h0000, div}, 4'hf);
    reg_write(SS, 32'(ss_m), 4'h1);
    // Length 64 goes in as zero
    reg_write(CTRL, (len % 64) | (32'd1 << CTRL_GO_BIT), 4'h3);
    for (int unsigned p = 0; p < len; p++) begin
      do @(negedge clock); while (!sck);
      high_clk = 0;
      while (sck) begin
        check_ss("ss in transfer", ss, ~ss_m);
        high_clk++;
        @(negedge clock);
      end
      check_data("sck high clocks", high_clk, 32'(div) + 1);
    end
    check_ss("ss after transfer", ss, '1);
    mask   = (len == 64) ? '1 : (64'd1 << len) - 64'd1;
    exp_rx = {tx1_m, tx0_m} & mask;
    reg_read(CTRL, rdata);
    check_data("ctrl after transfer", rdata, len % 64);
    reg_read(RX0_TX0, rdata);
    check_data("rx0", rdata, exp_rx[31:0]);
    reg_read(RX1_TX1, rdata);
    check_data("rx1", rdata, exp_rx[63:32]);
  endtask

  task automatic irq_sequence();
    reg_write(DIVIDER, 32'd0, 4'hf);
    reg_write(SS, 32'h2, 4'h1);
    reg_write(CTRL, 32'd8 | (32'd1 << CTRL_GO_BIT) | (32'd1 << CTRL_IE_BIT), 4'h3);
    wait_idle();
    @(negedge clock);
    check_irq("irq after transfer", irq, 1'b1);
    reg_write(CTRL, 32'd8, 4'h3);
    @(negedge clock);
    check_irq("irq after ctrl write", irq, 1'b0);
    reg_write(CTRL, 32'd8 | (32'd1 << CTRL_GO_BIT), 4'h3);
    wait_idle();
    @(negedge clock);
    check_irq("irq with ie clear", irq, 1'b0);
  endtask

  task automatic flash_read_check();
    logic [31:0] addr;
    logic [31:0] rdata;
    logic [31:0] exp;
    logic [23:0] a;
    logic [1:0]  resp;
    addr = FLASH_BASE | ((next_rand() >> 4) & 32'h0fff_ffff);
    a    = addr[23:0];
    // First byte lands in the upper bits
    exp  = {flash_byte(a), flash_byte(a + 24'd1), flash_byte(a + 24'd2), flash_byte(a + 24'd3)};
    apb_access(1'b0, addr, 32'd0, 4'h0, rdata, resp);
    check_resp("flash read", resp, 2'b00);
    check_data("flash read data", rdata, exp);
  endtask

  initial begin
    logic [31:0] rdata;
    logic [1:0]  resp;
    err_cnt   = 0;
    check_cnt = 0;
    rng_state = 32'hca17c39e;
    reset     = 1'b1;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    pstrb     = '0;
    tx0_m     = '0;
    tx1_m     = '0;
    div_m     = '0;
    ss_m      = '0;
    repeat (2) @(posedge clock);
    reset <= 1'b0;
    @(negedge clock);
    check_resp("after reset", {pready, pslverr}, 2'b00);
    check_irq("after reset", irq, 1'b0);
    check_ss("after reset", ss, '1);
    check_data("sck after reset", 32'(sck), 32'd0);

    random_reg_writes();
    for (int unsigned i = 0; i < NUM_LOOPBACK; i++) loopback_transfer();
    irq_sequence();
    for (int unsigned i = 0; i < NUM_FLASH; i++) flash_read_check();

    // Illegal accesses end at once with an error
    apb_access(1'b1, FLASH_BASE + 32'h100, next_rand(), 4'hf, rdata, resp);
    check_resp("flash write", resp, 2'b11);
    apb_access(1'b0, 32'h2000_0000, 32'd0, 4'h0, rdata, resp);
    check_resp("unmapped read", resp, 2'b11);
    apb_access(1'b1, 32'h1000_2000, next_rand(), 4'hf, rdata, resp);
    check_resp("unmapped write", resp, 2'b11);
    check_ss("idle at end", ss, '1);

    $display("Checks run: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

/* files.f */
common/spi_pkg.sv
logic/apb_xip_mux.sv
xip/xip_sequencer.sv
spi/spi_regs.sv
spi/spi_shifter.sv
logic/spi_apb_top.sv
dv/flash_model.sv
dv/tb_spi_apb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_spi_apb \
  -f files.f --Mdir obj_dir -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "TEST PASSED" sim.log; then
  exit 0
fi
exit 1
